/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_axi_adxl345
FILELIST := all.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
FAIL_MSG := *** TEST FAILED ***
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	@! grep -qF "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
+incdir+include
src/adxl_pkg.sv
src/reg_access_if.sv
src/cmd_if.sv
src/axil_slave.sv
src/adxl_reg_mirror.sv
src/bus_sequencer.sv
src/cmd_queue.sv
src/axi_adxl345.sv
tb/tb_axi_adxl345.sv

/* include/adxl_macros.svh */
`ifndef ADXL_MACROS_SVH
`define ADXL_MACROS_SVH

`define ADXL_AXI_DATA_W       32
`define ADXL_AXI_ADDR_W       6

`define ADXL_DEVICE_ADDR      7'h53
`define ADXL_LAST_ADDR        6'h39   // end of sweep, also read length
`define ADXL_WRITE_CMD        8'h02

// one bit per byte address, set where the host may write
`define ADXL_WRITE_MASK       64'h0102_F7FF_E000_0000

`define ADXL_REQUEST_INTERVAL 64      // idle cycles between reads
`define ADXL_QUEUE_DEPTH      16

`endif

/* src/adxl_pkg.sv */
`include "adxl_macros.svh"

package adxl_pkg;

    typedef logic [`ADXL_AXI_ADDR_W-1:0]   axi_addr_t;
    typedef logic [`ADXL_AXI_DATA_W-1:0]   axi_data_t;
    typedef logic [`ADXL_AXI_DATA_W/8-1:0] axi_strb_t;

    typedef logic [7:0] byte_t;
    typedef logic [5:0] reg_addr_t;   // 64 mirror bytes

    typedef enum logic [2:0] {
        idle,
        check,
        send_write,
        next_addr,
        send_read,
        receive
    } seq_state_t;

endpackage

/* src/adxl_reg_mirror.sv */
`timescale 1ns/1ps
`include "adxl_macros.svh"

module adxl_reg_mirror import adxl_pkg::*; (
    input  logic         S_AXI_LITE_ACLK,
    input  logic         S_AXI_LITE_ARESETN,
    output logic         pending_any,
    input  reg_addr_t    seq_addr,
    output logic         seq_pending,
    output byte_t        seq_byte,
    input  logic         clear_pending,
    input  logic         rx_wr,
    input  byte_t        rx_data,
    reg_access_if.mirror bus
);

    localparam logic [63:0] write_mask = `ADXL_WRITE_MASK;

    byte_t       regs [64];
    logic [63:0] pending;
    logic [63:0] host_hit;
    logic [63:0] seq_hit;
    byte_t       host_byte [64];

    for (genvar i = 0; i < 64; i++) begin : g_byte
        localparam reg_addr_t byte_addr = reg_addr_t'(i);

        assign host_hit[i]  = bus.wr_en && (bus.wr_word == byte_addr[5:2])
                              && bus.wr_strb[byte_addr[1:0]] && write_mask[i];
        assign seq_hit[i]   = (seq_addr == byte_addr);
        assign host_byte[i] = bus.wr_data[8*(i%4) +: 8];
    end

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            regs    <= '{default: '0};
            pending <= '0;
        end else begin
            for (int i = 0; i < 64; i++) begin
                if (host_hit[i]) begin
                    regs[i]    <= host_byte[i];   // host beats sensor data
                    pending[i] <= 1'b1;
                end else begin
                    if (rx_wr && seq_hit[i])
                        regs[i] <= rx_data;
                    if (clear_pending && seq_hit[i])
                        pending[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++)
            bus.rd_data[8*b +: 8] = regs[{bus.rd_word, 2'(b)}];
    end

    assign pending_any = |pending;
    assign seq_pending = pending[seq_addr];
    assign seq_byte    = regs[seq_addr];

endmodule

/* src/axi_adxl345.sv */
`timescale 1ns/1ps

module axi_adxl345 import adxl_pkg::*; (
    input  logic       S_AXI_LITE_ACLK,
    input  logic       S_AXI_LITE_ARESETN,
    input  axi_addr_t  S_AXI_LITE_AWADDR,
    input  logic       S_AXI_LITE_AWVALID,
    output logic       S_AXI_LITE_AWREADY,
    input  axi_data_t  S_AXI_LITE_WDATA,
    input  axi_strb_t  S_AXI_LITE_WSTRB,
    input  logic       S_AXI_LITE_WVALID,
    output logic       S_AXI_LITE_WREADY,
    output logic [1:0] S_AXI_LITE_BRESP,
    output logic       S_AXI_LITE_BVALID,
    input  logic       S_AXI_LITE_BREADY,
    input  axi_addr_t  S_AXI_LITE_ARADDR,
    input  logic       S_AXI_LITE_ARVALID,
    output logic       S_AXI_LITE_ARREADY,
    output axi_data_t  S_AXI_LITE_RDATA,
    output logic [1:0] S_AXI_LITE_RRESP,
    output logic       S_AXI_LITE_RVALID,
    input  logic       S_AXI_LITE_RREADY,
    output byte_t      M_AXIS_TDATA,
    output byte_t      M_AXIS_TUSER,
    output logic       M_AXIS_TVALID,
    output logic       M_AXIS_TLAST,
    input  logic       M_AXIS_TREADY,
    input  byte_t      S_AXIS_TDATA,
    input  byte_t      S_AXIS_TUSER,
    input  logic       S_AXIS_TVALID,
    input  logic       S_AXIS_TLAST,
    output logic       S_AXIS_TREADY
);

    reg_access_if reg_bus ();
    cmd_if        cmd_bus ();

    logic      pending_any;
    reg_addr_t seq_addr;
    logic      seq_pending;
    byte_t     seq_byte;
    logic      clear_pending;
    logic      rx_wr;
    byte_t     rx_data;

    assign S_AXIS_TREADY = 1'b1;   // mirror always takes a byte

    axil_slave u_axil_slave (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .awaddr             (S_AXI_LITE_AWADDR),
        .awvalid            (S_AXI_LITE_AWVALID),
        .awready            (S_AXI_LITE_AWREADY),
        .wdata              (S_AXI_LITE_WDATA),
        .wstrb              (S_AXI_LITE_WSTRB),
        .wvalid             (S_AXI_LITE_WVALID),
        .wready             (S_AXI_LITE_WREADY),
        .bresp              (S_AXI_LITE_BRESP),
        .bvalid             (S_AXI_LITE_BVALID),
        .bready             (S_AXI_LITE_BREADY),
        .araddr             (S_AXI_LITE_ARADDR),
        .arvalid            (S_AXI_LITE_ARVALID),
        .arready            (S_AXI_LITE_ARREADY),
        .rdata              (S_AXI_LITE_RDATA),
        .rresp              (S_AXI_LITE_RRESP),
        .rvalid             (S_AXI_LITE_RVALID),
        .rready             (S_AXI_LITE_RREADY),
        .bus                (reg_bus.slave)
    );

    adxl_reg_mirror u_adxl_reg_mirror (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .pending_any        (pending_any),
        .seq_addr           (seq_addr),
        .seq_pending        (seq_pending),
        .seq_byte           (seq_byte),
        .clear_pending      (clear_pending),
        .rx_wr              (rx_wr),
        .rx_data            (rx_data),
        .bus                (reg_bus.mirror)
    );

    bus_sequencer u_bus_sequencer (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .pending_any        (pending_any),
        .seq_addr           (seq_addr),
        .seq_pending        (seq_pending),
        .seq_byte           (seq_byte),
        .clear_pending      (clear_pending),
        .rx_wr              (rx_wr),
        .rx_data            (rx_data),
        .rx_tdata           (S_AXIS_TDATA),
        .rx_tvalid          (S_AXIS_TVALID),
        .rx_tlast           (S_AXIS_TLAST),
        .cmd                (cmd_bus.producer)
    );

    cmd_queue u_cmd_queue (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .M_AXIS_TDATA       (M_AXIS_TDATA),
        .M_AXIS_TUSER       (M_AXIS_TUSER),
        .M_AXIS_TLAST       (M_AXIS_TLAST),
        .M_AXIS_TVALID      (M_AXIS_TVALID),
        .M_AXIS_TREADY      (M_AXIS_TREADY),
        .cmd                (cmd_bus.queue)
    );

endmodule

/* src/axil_slave.sv */
`timescale 1ns/1ps

module axil_slave import adxl_pkg::*; (
    input  logic        S_AXI_LITE_ACLK,
    input  logic        S_AXI_LITE_ARESETN,
    input  axi_addr_t   awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  axi_data_t   wdata,
    input  axi_strb_t   wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  axi_addr_t   araddr,
    input  logic        arvalid,
    output logic        arready,
    output axi_data_t   rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    reg_access_if.slave bus
);

    logic       aw_en;
    logic       wr_accept;
    logic       rd_accept;
    logic [3:0] aw_word;
    logic [3:0] ar_word;

    assign wr_accept = ~awready && awvalid && wvalid && aw_en;
    assign rd_accept = ~arready && arvalid && ~rvalid;

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_en   <= 1'b1;
            bvalid  <= 1'b0;
        end else begin
            awready <= wr_accept;   // address and data taken together
            wready  <= wr_accept;
            if (wr_accept)
                aw_en <= 1'b0;
            else if (bready && bvalid)
                aw_en <= 1'b1;   // open for the next write
            if (bus.wr_en)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (wr_accept)
            aw_word <= awaddr[5:2];
        if (rd_accept)
            ar_word <= araddr[5:2];
        if (arready && arvalid)
            rdata <= bus.rd_data;
    end

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= rd_accept;
            if (arready && arvalid)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    assign bus.wr_en   = awready && awvalid && wready && wvalid;
    assign bus.wr_word = aw_word;
    assign bus.wr_data = wdata;
    assign bus.wr_strb = wstrb;
    assign bus.rd_word = ar_word;

    assign bresp = 2'b00;   // okay
    assign rresp = 2'b00;

endmodule

/* src/bus_sequencer.sv */
`timescale 1ns/1ps
`include "adxl_macros.svh"

module bus_sequencer import adxl_pkg::*; (
    input  logic      S_AXI_LITE_ACLK,
    input  logic      S_AXI_LITE_ARESETN,
    input  logic      pending_any,
    output reg_addr_t seq_addr,
    input  logic      seq_pending,
    input  byte_t     seq_byte,
    output logic      clear_pending,
    output logic      rx_wr,
    output byte_t     rx_data,
    input  byte_t     rx_tdata,
    input  logic      rx_tvalid,
    input  logic      rx_tlast,
    cmd_if.producer   cmd
);

    localparam int                 timer_w    = $clog2(`ADXL_REQUEST_INTERVAL);
    localparam logic [timer_w-1:0] timer_end  = timer_w'(`ADXL_REQUEST_INTERVAL - 1);
    localparam byte_t              write_user = {`ADXL_DEVICE_ADDR, 1'b0};
    localparam byte_t              read_user  = {`ADXL_DEVICE_ADDR, 1'b1};

    seq_state_t         state;
    logic [1:0]         word_cnt;   // command, address, data
    logic [timer_w-1:0] timer;
    logic               sending;
    logic               last_word;

    assign sending   = (state == send_write || state == send_read) && !cmd.full;
    assign last_word = (word_cnt == 2'd2);

    always_comb begin
        cmd.push = sending;
        cmd.last = (state == send_read) || last_word;
        if (state == send_read) begin
            cmd.user = read_user;
            cmd.data = byte_t'(`ADXL_LAST_ADDR);   // bytes to read back
        end else begin
            cmd.user = write_user;
            case (word_cnt)
                2'd0:    cmd.data = `ADXL_WRITE_CMD;
                2'd1:    cmd.data = byte_t'(seq_addr);
                default: cmd.data = seq_byte;
            endcase
        end
    end

    assign clear_pending = sending && (state == send_write) && last_word;
    assign rx_wr         = (state == receive) && rx_tvalid;
    assign rx_data       = rx_tdata;

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            state    <= idle;
            seq_addr <= '0;
            word_cnt <= '0;
            timer    <= '0;
        end else begin
            case (state)
                idle: begin
                    seq_addr <= '0;
                    if (pending_any)
                        state <= check;
                    else if (timer == timer_end)
                        state <= send_read;
                    else
                        timer <= timer + 1'b1;
                end
                check:
                    state <= seq_pending ? send_write : next_addr;
                send_write:
                    if (!cmd.full) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            word_cnt <= '0;
                            state    <= next_addr;
                        end
                    end
                next_addr:
                    if (seq_addr == `ADXL_LAST_ADDR) begin
                        state <= idle;
                    end else begin
                        seq_addr <= seq_addr + 1'b1;
                        state    <= check;
                    end
                send_read:
                    if (!cmd.full)
                        state <= receive;
                receive: begin
                    timer <= '0;
                    if (rx_tvalid) begin
                        seq_addr <= seq_addr + 1'b1;   // fill from byte 0 up
                        if (rx_tlast)
                            state <= idle;
                    end
                end
                default:
                    state <= idle;
            endcase
        end
    end

endmodule

/* src/cmd_if.sv */
`timescale 1ns/1ps

interface cmd_if import adxl_pkg::*; ();

    logic  push;
    byte_t data;
    byte_t user;   // device address with r/w bit
    logic  last;
    logic  full;

    modport producer (
        output push, data, user, last,
        input  full
    );

    modport queue (
        input  push, data, user, last,
        output full
    );

endinterface

/* src/cmd_queue.sv */
`timescale 1ns/1ps
`include "adxl_macros.svh"

module cmd_queue import adxl_pkg::*; (
    input  logic  S_AXI_LITE_ACLK,
    input  logic  S_AXI_LITE_ARESETN,
    output byte_t M_AXIS_TDATA,
    output byte_t M_AXIS_TUSER,
    output logic  M_AXIS_TLAST,
    output logic  M_AXIS_TVALID,
    input  logic  M_AXIS_TREADY,
    cmd_if.queue  cmd
);

    localparam int depth = `ADXL_QUEUE_DEPTH;
    localparam int ptr_w = $clog2(depth);

    byte_t            data_mem [depth];
    byte_t            user_mem [depth];
    logic [depth-1:0] last_mem;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             pop;

    assign pop           = M_AXIS_TVALID && M_AXIS_TREADY;
    assign M_AXIS_TVALID = (count != '0);
    assign M_AXIS_TDATA  = data_mem[rd_ptr];
    assign M_AXIS_TUSER  = user_mem[rd_ptr];
    assign M_AXIS_TLAST  = last_mem[rd_ptr];
    assign cmd.full      = (count == (ptr_w+1)'(depth));

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (cmd.push) begin
            data_mem[wr_ptr] <= cmd.data;
            user_mem[wr_ptr] <= cmd.user;
            last_mem[wr_ptr] <= cmd.last;
        end
    end

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd.push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({cmd.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/reg_access_if.sv */
`timescale 1ns/1ps

interface reg_access_if import adxl_pkg::*; ();

    logic       wr_en;     // one pulse per accepted write
    logic [3:0] wr_word;
    axi_data_t  wr_data;
    axi_strb_t  wr_strb;
    logic [3:0] rd_word;
    axi_data_t  rd_data;

    modport slave (
        output wr_en, wr_word, wr_data, wr_strb, rd_word,
        input  rd_data
    );

    modport mirror (
        input  wr_en, wr_word, wr_data, wr_strb, rd_word,
        output rd_data
    );

endinterface

/* tb/adxl_stim.txt */
// columns: op f1 f2 f3, all hex; op 0 ends the run
// 1 write addr data strb | 2 read addr expected 0 | 3 out byte data user last
// 4 in byte data last 0 | 5 hold tready low for f1 cycles | 6 out write cmd addr data 0
3 39 A7 1        // refresh request after reset
1 20 A1B2C3D4 F
2 20 A1B2C3D4 0
1 00 FFFFFFFF F  // nothing writable at 0x00
2 00 00000000 0
1 1C 11223344 F  // 0x1c itself is read only
2 1C 11223300 0
1 20 0000EE00 2
2 20 A1B2EED4 0
1 2C 0000005A 1
2 2C 0000005A 0
4 10 0 0         // answer to the refresh request
4 20 0 0
4 30 0 0
4 40 0 0
4 50 1 0
2 00 40302010 0
2 04 00000050 0
5 96 0 0         // let the queue fill up
6 1D 33 0
6 1E 22 0
6 1F 11 0
6 20 D4 0
6 21 EE 0
6 22 B2 0
6 23 A1 0
6 2C 5A 0
3 39 A7 1        // next refresh once the sweep is done
0 0 0 0

/* tb/tb_axi_adxl345.sv */
`timescale 1ns/1ps
`include "adxl_macros.svh"

module tb_axi_adxl345 import adxl_pkg::*; ();

    localparam int    timeout    = 2000;   // cycles per wait
    localparam int    stim_words = 256;
    localparam byte_t write_user = 8'hA6;  // device 0x53 with write bit

    logic        S_AXI_LITE_ACLK;
    logic        S_AXI_LITE_ARESETN;
    axi_addr_t   awaddr;
    logic        awvalid;
    logic        awready;
    axi_data_t   wdata;
    axi_strb_t   wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    axi_addr_t   araddr;
    logic        arvalid;
    logic        arready;
    axi_data_t   rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    byte_t       m_tdata;
    byte_t       m_tuser;
    logic        m_tvalid;
    logic        m_tlast;
    logic        m_tready;
    byte_t       s_tdata;
    byte_t       s_tuser;
    logic        s_tvalid;
    logic        s_tlast;
    logic        s_tready;

    logic [31:0] stim_mem [stim_words];
    int          mismatches;
    int          failures;
    logic        aborted;

    axi_adxl345 u_axi_adxl345 (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .S_AXI_LITE_AWADDR  (awaddr),
        .S_AXI_LITE_AWVALID (awvalid),
        .S_AXI_LITE_AWREADY (awready),
        .S_AXI_LITE_WDATA   (wdata),
        .S_AXI_LITE_WSTRB   (wstrb),
        .S_AXI_LITE_WVALID  (wvalid),
        .S_AXI_LITE_WREADY  (wready),
        .S_AXI_LITE_BRESP   (bresp),
        .S_AXI_LITE_BVALID  (bvalid),
        .S_AXI_LITE_BREADY  (bready),
        .S_AXI_LITE_ARADDR  (araddr),
        .S_AXI_LITE_ARVALID (arvalid),
        .S_AXI_LITE_ARREADY (arready),
        .S_AXI_LITE_RDATA   (rdata),
        .S_AXI_LITE_RRESP   (rresp),
        .S_AXI_LITE_RVALID  (rvalid),
        .S_AXI_LITE_RREADY  (rready),
        .M_AXIS_TDATA       (m_tdata),
        .M_AXIS_TUSER       (m_tuser),
        .M_AXIS_TVALID      (m_tvalid),
        .M_AXIS_TLAST       (m_tlast),
        .M_AXIS_TREADY      (m_tready),
        .S_AXIS_TDATA       (s_tdata),
        .S_AXIS_TUSER       (s_tuser),
        .S_AXIS_TVALID      (s_tvalid),
        .S_AXIS_TLAST       (s_tlast),
        .S_AXIS_TREADY      (s_tready)
    );

    initial begin
        S_AXI_LITE_ACLK = 1'b0;
        forever #50 S_AXI_LITE_ACLK = ~S_AXI_LITE_ACLK;
    end

    task automatic log_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("MISMATCH at %0d ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
        mismatches++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0d ns: %s did not happen within %0d cycles", $time, what, timeout);
        failures++;
        aborted = 1'b1;
    endtask

    task automatic write_word(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
        int n;
        @(negedge S_AXI_LITE_ACLK);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        n = 0;
        while (!(awready && wready) && n < timeout) begin
            @(negedge S_AXI_LITE_ACLK);
            n++;
        end
        assert (n < timeout) else abort_on_timeout("write address and data ready");
        if (aborted)
            return;
        @(negedge S_AXI_LITE_ACLK);   // handshake done at the edge before
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid && n < timeout) begin
            @(negedge S_AXI_LITE_ACLK);
            n++;
        end
        assert (n < timeout) else abort_on_timeout("write response");
        if (aborted)
            return;
        assert (bresp == 2'b00) else log_mismatch("write response code", 32'(bresp), 32'd0);
        @(negedge S_AXI_LITE_ACLK);
        bready = 1'b0;
    endtask

    task automatic read_word(input axi_addr_t addr, input axi_data_t exp);
        int n;
        @(negedge S_AXI_LITE_ACLK);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        n = 0;
        while (!arready && n < timeout) begin
            @(negedge S_AXI_LITE_ACLK);
            n++;
        end
        assert (n < timeout) else abort_on_timeout("read address ready");
        if (aborted)
            return;
        @(negedge S_AXI_LITE_ACLK);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < timeout) begin
            @(negedge S_AXI_LITE_ACLK);
            n++;
        end
        assert (n < timeout) else abort_on_timeout("read data valid");
        if (aborted)
            return;
        assert (rdata == exp && rresp == 2'b00)
            else log_mismatch($sformatf("read of 0x%0h", addr), rdata, exp);
        @(negedge S_AXI_LITE_ACLK);
        rready = 1'b0;
    endtask

    task automatic take_out_byte(input byte_t data, input byte_t user, input logic last);
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        while (!got && n < timeout) begin
            @(negedge S_AXI_LITE_ACLK);
            m_tready = ($urandom % 4) != 0;   // random gaps
            got      = m_tready && m_tvalid;
            n++;
        end
        assert (got) else abort_on_timeout("output stream byte");
        if (aborted)
            return;
        assert (m_tdata == data && m_tuser == user && m_tlast == last)
            else log_mismatch("output byte {last,user,data}",
                              32'({m_tlast, m_tuser, m_tdata}), 32'({last, user, data}));
        @(negedge S_AXI_LITE_ACLK);
        m_tready = 1'b0;
    endtask

    // command byte, register address, then data with last
    task automatic check_write_cmd(input byte_t addr, input byte_t data);
        take_out_byte(`ADXL_WRITE_CMD, write_user, 1'b0);
        if (!aborted)
            take_out_byte(addr, write_user, 1'b0);
        if (!aborted)
            take_out_byte(data, write_user, 1'b1);
    endtask

    task automatic send_in_byte(input byte_t data, input logic last);
        int n;
        @(negedge S_AXI_LITE_ACLK);
        s_tdata  = data;
        s_tlast  = last;
        s_tvalid = 1'b1;
        n = 0;
        while (!s_tready && n < timeout) begin
            @(negedge S_AXI_LITE_ACLK);
            n++;
        end
        assert (n < timeout) else abort_on_timeout("input stream ready");
        @(negedge S_AXI_LITE_ACLK);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    task automatic stall_output(input int cycles);
        @(negedge S_AXI_LITE_ACLK);
        m_tready = 1'b0;
        repeat (cycles) @(negedge S_AXI_LITE_ACLK);
    endtask

    initial begin
        int          pc;
        int          ops_done;
        logic [31:0] op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        void'($urandom(91024));
        S_AXI_LITE_ARESETN = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        m_tready = 1'b0;
        s_tdata  = '0;
        s_tuser  = '0;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        mismatches = 0;
        failures   = 0;
        aborted    = 1'b0;
        ops_done   = 0;
        $readmemh("tb/adxl_stim.txt", stim_mem);
        repeat (2) @(negedge S_AXI_LITE_ACLK);
        S_AXI_LITE_ARESETN = 1'b1;

        pc = 0;
        while (!aborted && pc < stim_words && stim_mem[pc] != 32'd0) begin
            op = stim_mem[pc];
            f1 = stim_mem[pc+1];
            f2 = stim_mem[pc+2];
            f3 = stim_mem[pc+3];
            case (op)
                32'd1:   write_word(f1[5:0], f2, f3[3:0]);
                32'd2:   read_word(f1[5:0], f2);
                32'd3:   take_out_byte(f1[7:0], f2[7:0], f3[0]);
                32'd4:   send_in_byte(f1[7:0], f2[0]);
                32'd5:   stall_output(int'(f1));
                32'd6:   check_write_cmd(f1[7:0], f2[7:0]);
                default: begin
                    $display("unknown operation 0x%0h at stimulus word %0d", op, pc);
                    failures++;
                    aborted = 1'b1;
                end
            endcase
            ops_done++;
            pc += 4;
        end
        assert (ops_done > 0) else begin
            $display("no operations could be read from tb/adxl_stim.txt");
            failures++;
        end

        $display("error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
